// ==== afu_job_top.f ====
+incdir+rtl
rtl/afu_pkg.sv
rtl/parity_check.sv
rtl/job_control.sv
rtl/error_log.sv
rtl/afu_job_top.sv
verification/afu_job_checker.sv
verification/afu_job_tb.sv

// ==== rtl/afu_job_top.sv ====
`timescale 1ns/10ps

module afu_job_top import afu_pkg::*; (
  input  logic       clock,
  input  logic       rstn,
  input  logic       job_valid,
  input  command_t   job_command,
  input  logic       job_command_parity,
  input  address_t   job_address,
  input  logic       job_address_parity,
  output job_err_t   job_errors,
  output logic       running,
  output logic       done,
  output error_vec_t error,
  output logic       reset_job,
  output logic       cack,
  output logic       yield,
  output logic       timebase_request,
  output logic       parity_enabled
);

  logic       invalid_cmd;
  error_vec_t report_errors;

  // Dedicated mode, no LLCMD, yield or timebase
  assign cack             = 1'b0;
  assign yield            = 1'b0;
  assign timebase_request = 1'b0;
  assign parity_enabled   = 1'b1;

  job_control i_job_control (
    .clock              (clock),
    .rstn               (rstn),
    .job_valid          (job_valid),
    .job_command        (job_command),
    .job_command_parity (job_command_parity),
    .job_address        (job_address),
    .job_address_parity (job_address_parity),
    .report_errors      (report_errors),
    .job_errors         (job_errors),
    .invalid_cmd        (invalid_cmd),
    .running            (running),
    .done               (done),
    .reset_job          (reset_job),
    .error              (error)
  );

  error_log i_error_log (
    .clock         (clock),
    .rstn          (rstn),
    .job_errors    (job_errors),
    .invalid_cmd   (invalid_cmd),
    .reset_job     (reset_job),
    .report_errors (report_errors)
  );

endmodule

// ==== rtl/afu_params.svh ====
`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// Parity sense, 1 means odd
`define ODD_PARITY 1'b1

// Length of the reset pulse into the accelerator
`define RESET_CYCLES 4

// Positions in the error vector
`define ERR_CMD_BIT     0
`define ERR_ADDR_BIT    1
`define INVALID_CMD_BIT 2

`endif

// ==== rtl/afu_pkg.sv ====
package afu_pkg;

  ////////////////////////////////////////////////////////////
  // Job command codes
  ////////////////////////////////////////////////////////////

  // Any code outside this set is flagged as invalid
  typedef enum logic [7:0] {
    TIMEBASE = 8'h42,
    RESET    = 8'h80,
    START    = 8'h90
  } job_cmd_t;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  typedef logic [7:0]  command_t;    // Raw command word from host
  typedef logic [63:0] address_t;    // Job effective address
  typedef logic [63:0] error_vec_t;  // Error vector reported with done

  // Bit 1 command parity, bit 0 address parity
  typedef logic [1:0]  job_err_t;

endpackage

// ==== rtl/error_log.sv ====
`timescale 1ns/10ps
`include "afu_params.svh"

module error_log import afu_pkg::*; (
  input  logic       clock,
  input  logic       rstn,
  input  job_err_t   job_errors,
  input  logic       invalid_cmd,
  input  logic       reset_job,
  output error_vec_t report_errors
);

  job_err_t prev_errors;
  job_err_t new_errors;
  logic     reset_job_q;
  logic     log_clear;

  // job_errors is a level, log only fresh errors
  assign new_errors = job_errors & ~prev_errors;

  // End of the job reset pulse
  assign log_clear = reset_job & ~reset_job_q;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      prev_errors   <= '0;
      reset_job_q   <= 1'b1;
      report_errors <= '0;
    end else begin
      prev_errors <= job_errors;
      reset_job_q <= reset_job;
      if (log_clear) begin
        report_errors <= '0;
      end else begin
        if (new_errors[1]) report_errors[`ERR_CMD_BIT]     <= 1'b1;
        if (new_errors[0]) report_errors[`ERR_ADDR_BIT]    <= 1'b1;
        if (invalid_cmd)   report_errors[`INVALID_CMD_BIT] <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/job_control.sv ====
`timescale 1ns/10ps
`include "afu_params.svh"

module job_control import afu_pkg::*; (
  input  logic       clock,
  input  logic       rstn,
  input  logic       job_valid,
  input  command_t   job_command,
  input  logic       job_command_parity,
  input  address_t   job_address,
  input  logic       job_address_parity,
  input  error_vec_t report_errors,
  output job_err_t   job_errors,
  output logic       invalid_cmd,
  output logic       running,
  output logic       done,
  output logic       reset_job,
  output error_vec_t error
);

  localparam int CNT_W = $clog2(`RESET_CYCLES + 1);

  typedef enum logic [1:0] {
    idle,
    resetting,
    finishing
  } job_state_t;

  job_state_t       state;
  logic [CNT_W-1:0] count;
  logic             is_start;
  logic             is_reset;
  logic             is_known;
  logic             start_job;
  command_t         command;
  address_t         address;
  logic             command_parity;
  logic             address_parity;
  logic             command_err;
  logic             address_err;

  ////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////

  assign is_start = (job_command == START);
  assign is_reset = (job_command == RESET);
  assign is_known = is_start || is_reset || (job_command == TIMEBASE);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      start_job   <= 1'b0;
      invalid_cmd <= 1'b0;
      running     <= 1'b0;
    end else begin
      start_job   <= job_valid && is_start;
      invalid_cmd <= job_valid && !is_known;  // One cycle pulse
      if (job_valid && is_reset) begin
        running <= 1'b0;
      end else if (start_job) begin
        running <= 1'b1;  // Held until the next reset
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Parity check
  ////////////////////////////////////////////////////////////

  // Zero data with matching parity after done clears stale errors
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command        <= '0;
      address        <= '0;
      command_parity <= `ODD_PARITY;
      address_parity <= `ODD_PARITY;
    end else if (job_valid) begin
      command        <= job_command;
      address        <= job_address;
      command_parity <= job_command_parity;
      address_parity <= job_address_parity;
    end else if (state == finishing) begin
      command        <= '0;
      address        <= '0;
      command_parity <= `ODD_PARITY;
      address_parity <= `ODD_PARITY;
    end
  end

  parity_check #(
    .BITS (8)
  ) i_command_parity (
    .clock (clock),
    .rstn  (rstn),
    .data  (command),
    .par   (command_parity),
    .err   (command_err)
  );

  parity_check #(
    .BITS (64)
  ) i_address_parity (
    .clock (clock),
    .rstn  (rstn),
    .data  (address),
    .par   (address_parity),
    .err   (address_err)
  );

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      job_errors <= '0;
    end else begin
      job_errors <= {command_err, address_err};
    end
  end

  ////////////////////////////////////////////////////////////
  // Reset sequencer and done
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state     <= idle;
      count     <= '0;
      reset_job <= 1'b1;
      done      <= 1'b0;
      error     <= '0;
    end else begin
      done  <= 1'b0;
      error <= '0;  // Error is only valid with done
      case (state)
        idle: begin
          if (job_valid && is_reset) begin
            reset_job <= 1'b0;
            count     <= CNT_W'(`RESET_CYCLES - 1);
            state     <= resetting;
          end
        end
        resetting: begin
          if (count == '0) begin
            reset_job <= 1'b1;
            state     <= finishing;
          end else begin
            count <= count - 1'b1;
          end
        end
        finishing: begin
          done  <= 1'b1;
          error <= report_errors;  // Sampled before the log clears
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// ==== rtl/parity_check.sv ====
`timescale 1ns/10ps
`include "afu_params.svh"

module parity_check #(
  parameter int BITS = 8
) (
  input  logic            clock,
  input  logic            rstn,
  input  logic [BITS-1:0] data,
  input  logic            par,
  output logic            err
);

  logic expected;

  // Parity bit that makes the total count of ones odd
  assign expected = (^data) ^ `ODD_PARITY;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      err <= 1'b0;
    end else begin
      err <= expected ^ par;  // High on mismatch
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the job control testbench
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module afu_job_tb -f afu_job_top.f \
       --Mdir obj_dir -o afu_job_sim \
  && { ./obj_dir/afu_job_sim > sim.log 2>&1 || true; } \
  && cat sim.log \
  && ! grep -q "STATUS: FAIL" sim.log \
  && grep -q "STATUS: PASS" sim.log \
  || { echo "Build or simulation failed, see sim.log"; exit 1; }

// ==== verification/afu_job_checker.sv ====
`timescale 1ns/10ps
`include "afu_params.svh"

module afu_job_checker import afu_pkg::*; (
  input  logic       clock,
  input  logic       rstn,
  input  logic       job_valid,
  input  command_t   job_command,
  input  logic       job_command_parity,
  input  address_t   job_address,
  input  logic       job_address_parity,
  input  error_vec_t file_vector,
  input  job_err_t   job_errors,
  input  logic       running,
  input  logic       done,
  input  error_vec_t error,
  input  logic       reset_job,
  input  logic       cack,
  input  logic       yield,
  input  logic       timebase_request,
  input  logic       parity_enabled,
  output int         mismatch_count,
  output int         missing_done_count
);

  localparam int DONE_AGE     = `RESET_CYCLES + 1;  // Edges from capture to done
  localparam int DONE_TIMEOUT = `RESET_CYCLES + 4;

  int         mismatches = 0;
  int         missed_dones = 0;
  int         age;                // Edges since the last capture or -1 before any
  command_t   last_cmd;
  job_err_t   last_bits;
  logic       prev_running;
  error_vec_t sticky;             // Expected log contents
  error_vec_t file_done_vector;
  logic       is_reset_cmd;
  logic       is_start_cmd;
  logic       exp_running;
  logic       exp_reset_job;
  logic       exp_done;
  error_vec_t exp_error;
  job_err_t   exp_job_errors;
  logic       errors_settled;

  assign mismatch_count     = mismatches;
  assign missing_done_count = missed_dones;

  // True when data and parity bit do not add up to odd parity
  function automatic logic parity_error(input logic [63:0] data, input logic par);
    return ((^data) ^ par) != `ODD_PARITY;
  endfunction

  function automatic logic is_invalid(input command_t cmd);
    return !(cmd == START || cmd == RESET || cmd == TIMEBASE);
  endfunction

  // Error vector positions of one command's events
  function automatic error_vec_t event_bits(input job_err_t bits, input logic invalid);
    error_vec_t vec;
    vec = '0;
    vec[`ERR_CMD_BIT]     = bits[1];
    vec[`ERR_ADDR_BIT]    = bits[0];
    vec[`INVALID_CMD_BIT] = invalid;
    return vec;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model advanced on the edge the DUT samples
  ////////////////////////////////////////////////////////////

  always @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      age              <= -1;
      last_cmd         <= '0;
      last_bits        <= '0;
      prev_running     <= 1'b0;
      sticky           <= '0;
      file_done_vector <= '0;
    end else if (job_valid) begin
      age          <= 0;
      last_cmd     <= job_command;
      last_bits    <= {parity_error(64'(job_command), job_command_parity),
                       parity_error(job_address, job_address_parity)};
      prev_running <= exp_running;
      sticky       <= sticky | event_bits({parity_error(64'(job_command), job_command_parity),
                                           parity_error(job_address, job_address_parity)},
                                          is_invalid(job_command));
      file_done_vector <= file_vector;
    end else begin
      if (age >= 0 && age < 1000) begin
        age <= age + 1;
      end
      if (is_reset_cmd && age == DONE_AGE) begin
        sticky <= '0;  // Log restarts after done
      end
    end
  end

  assign is_reset_cmd   = (age >= 0) && (last_cmd == RESET);
  assign is_start_cmd   = (age >= 1) && (last_cmd == START);
  assign exp_running    = is_reset_cmd ? 1'b0 : (is_start_cmd ? 1'b1 : prev_running);
  assign exp_reset_job  = !(is_reset_cmd && age < `RESET_CYCLES);
  assign exp_done       = is_reset_cmd && age == DONE_AGE;
  assign exp_error      = exp_done ? sticky : '0;
  // Clean reload after done shows up two edges later
  assign exp_job_errors = (age < 0 || (is_reset_cmd && age >= DONE_AGE + 2)) ? 2'b00 :
                          last_bits;
  assign errors_settled = (age < 0) || (age >= 2);

  ////////////////////////////////////////////////////////////
  // Compare on the falling edge away from updates
  ////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    if (rstn) begin
      compare_value("running", 64'(exp_running), 64'(running));
      compare_value("reset_job", 64'(exp_reset_job), 64'(reset_job));
      compare_value("done", 64'(exp_done), 64'(done));
      compare_value("error", exp_error, error);
      if (errors_settled) begin
        compare_value("job_errors", 64'(exp_job_errors), 64'(job_errors));
      end
      if (exp_done) begin
        compare_value("error (input file)", file_done_vector, error);
      end
      compare_value("cack", 64'(1'b0), 64'(cack));  // Tied off at the top
      compare_value("yield", 64'(1'b0), 64'(yield));
      compare_value("timebase_request", 64'(1'b0), 64'(timebase_request));
      compare_value("parity_enabled", 64'(1'b1), 64'(parity_enabled));
    end
  end

  task automatic wait_for_done(input time start);
    int   cycles;
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(negedge clock);
      seen = done;
      cycles++;
    end
    if (!seen) begin
      $display("No done pulse within %0d cycles of the RESET command at %0t",
               DONE_TIMEOUT, start);
      missed_dones++;
    end
  endtask

  always begin
    @(posedge clock);
    if (rstn && job_valid && job_command == RESET) begin
      wait_for_done($time);
    end
  end

endmodule

// ==== verification/afu_job_tb.sv ====
`timescale 1ns/10ps
`include "afu_params.svh"

module afu_job_tb import afu_pkg::*; ();

  localparam int    GAP_CYCLES = `RESET_CYCLES + 6;
  localparam string INPUT_FILE = "verification/job_input.txt";

  logic       clock;
  logic       rstn;
  logic       job_valid;
  command_t   job_command;
  logic       job_command_parity;
  address_t   job_address;
  logic       job_address_parity;
  error_vec_t file_vector;   // Expected vector from the current line
  job_err_t   job_errors;
  logic       running;
  logic       done;
  error_vec_t error;
  logic       reset_job;
  logic       cack;
  logic       yield;
  logic       timebase_request;
  logic       parity_enabled;
  int         mismatch_count;
  int         missing_done_count;
  int         file_errors = 0;

  afu_job_top i_dut (
    .clock              (clock),
    .rstn               (rstn),
    .job_valid          (job_valid),
    .job_command        (job_command),
    .job_command_parity (job_command_parity),
    .job_address        (job_address),
    .job_address_parity (job_address_parity),
    .job_errors         (job_errors),
    .running            (running),
    .done               (done),
    .error              (error),
    .reset_job          (reset_job),
    .cack               (cack),
    .yield              (yield),
    .timebase_request   (timebase_request),
    .parity_enabled     (parity_enabled)
  );

  afu_job_checker i_checker (
    .clock              (clock),
    .rstn               (rstn),
    .job_valid          (job_valid),
    .job_command        (job_command),
    .job_command_parity (job_command_parity),
    .job_address        (job_address),
    .job_address_parity (job_address_parity),
    .file_vector        (file_vector),
    .job_errors         (job_errors),
    .running            (running),
    .done               (done),
    .error              (error),
    .reset_job          (reset_job),
    .cack               (cack),
    .yield              (yield),
    .timebase_request   (timebase_request),
    .parity_enabled     (parity_enabled),
    .mismatch_count     (mismatch_count),
    .missing_done_count (missing_done_count)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Odd parity bit for data inverted when good is low
  function automatic logic parity_for(input logic [63:0] data, input logic good);
    return (^data) ^ `ODD_PARITY ^ !good;
  endfunction

  // One strobe then idle long enough for a full reset sequence
  task automatic send_command(input command_t cmd, input address_t addr, input logic cpar,
                              input logic apar, input error_vec_t vec);
    @(posedge clock);
    job_valid          <= 1'b1;
    job_command        <= cmd;
    job_address        <= addr;
    job_command_parity <= cpar;
    job_address_parity <= apar;
    file_vector        <= vec;
    @(posedge clock);
    job_valid <= 1'b0;
    repeat (GAP_CYCLES) @(posedge clock);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus from the input file
  ////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          fields;
    int          line_no;
    int          commands;
    int          total;
    string       line;
    string       addr_tok;
    command_t    cmd;
    address_t    addr;
    logic        cp_ok;
    logic        ap_ok;
    error_vec_t  vec;

    void'($urandom(32'h9768));
    line_no    = 0;
    commands   = 0;
    rstn               <= 1'b0;
    job_valid          <= 1'b0;
    job_command        <= '0;
    job_address        <= '0;
    job_command_parity <= 1'b1;
    job_address_parity <= 1'b1;
    file_vector        <= '0;
    repeat (2) @(posedge clock);
    rstn <= 1'b1;
    repeat (3) @(posedge clock);  // Idle cycles after reset

    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", INPUT_FILE);
      file_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
          continue;
        end
        fields = $sscanf(line, "%h %s %b %b %h", cmd, addr_tok, cp_ok, ap_ok, vec);
        if (fields != 5) begin
          $display("Line %0d of %s could not be parsed", line_no, INPUT_FILE);
          file_errors++;
          continue;
        end
        if (addr_tok == "*") begin
          addr = {$urandom, $urandom};
        end else begin
          fields = $sscanf(addr_tok, "%h", addr);
        end
        send_command(cmd, addr, parity_for(64'(cmd), cp_ok), parity_for(addr, ap_ok), vec);
        commands++;
      end
      $fclose(fd);
      if (commands == 0) begin
        $display("The stimulus file %s holds no commands", INPUT_FILE);
        file_errors++;
      end
    end

    repeat (4) @(posedge clock);
    total = mismatch_count + missing_done_count + file_errors;
    $display("Errors: %0d mismatches, %0d missing done pulses, %0d stimulus file problems",
             mismatch_count, missing_done_count, file_errors);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/job_input.txt ====
# command(hex) address(hex, * for random) cmd_parity_ok addr_parity_ok done_vector(hex)
# parity_ok 1 sends correct odd parity, 0 sends it inverted
90 * 1 1 0
80 * 1 1 0
90 0000000000001000 0 1 1
80 * 1 1 1
80 * 1 1 0
90 00000000deadbeef 1 0 7
55 * 1 1 7
80 * 0 0 7
80 * 1 1 0
42 * 1 1 3
90 * 0 0 3
90 ffffffffffffffff 0 0 3
80 * 1 1 3
13 * 0 1 5
80 0123456789abcdef 1 1 5
80 * 1 1 0
